/* bench/rv_core_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_sva_checks (
    input wire                            clock,
    input wire                            rst_n,
    input wire mem_pkg::seq_state_t       state,
    input wire                            write_en,
    input wire [mem_pkg::word_width-1:0]  write_data
);

    import mem_pkg::*;

    // Successor of each sequencer phase.
    function automatic seq_state_t step_of(input seq_state_t s);
        case (s)
            seq_read:      return seq_wait_read;
            seq_wait_read: return seq_write;
            seq_write:     return seq_wait_write;
            default:       return seq_read;
        endcase
    endfunction

    state_order: assert property (@(posedge clock) disable iff (!rst_n)
        $past(rst_n) |-> state == step_of($past(state)))
        else $error("sequencer left its fixed four-state order");

    write_only_in_write_state: assert property (@(posedge clock) disable iff (!rst_n)
        write_en |-> state == seq_write)
        else $error("sequencer write enable high outside seq_write");

    // Each write is one more than the write a full pass earlier.
    write_is_increment: assert property (@(posedge clock) disable iff (!rst_n)
        (write_en && $past(write_en, 4)) |-> (write_data == $past(write_data, 4) + 32'd1))
        else $error("sequencer write data is not one more than its previous write");

endmodule

bind reg_incrementer rv_core_sva_checks sequencer_checks (
    .clock      (clock),
    .rst_n      (rst_n),
    .state      (state),
    .write_en   (write_en),
    .write_data (write_data)
);

`default_nettype wire

/* bench/rv_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

    import mem_pkg::*;
    import rv_pkg::*;

    localparam int ram_checks = 64;
    localparam int random_insns = 40;
    localparam int soak_cycles = 400;
    // About 720 cycles of tests, plus margin.
    localparam int max_cycles = 1200;

    localparam logic [opcode_width-1:0] class_opcodes [0:10] = '{
        opc_lui, opc_auipc, opc_jal, opc_jalr, opc_branch, opc_load,
        opc_store, opc_alu_imm, opc_alu_reg, opc_system, 7'b1111111
    };

    // Expected result and the edge count at which it becomes visible.
    typedef struct packed {
        logic [31:0]           due;
        logic [word_width-1:0] value;
    } word_exp_t;

    typedef struct packed {
        logic [31:0]   due;
        decoded_insn_t value;
    } dec_exp_t;

    logic                      clock;
    logic                      rst_n;
    logic                      led;
    mem_req_t                  inst_req;
    mem_req_t                  data_req;
    logic [word_width-1:0]     inst_rdata;
    logic [word_width-1:0]     data_rdata;
    logic [reg_addr_width-1:0] reg_read_addr;
    logic                      reg_read_en;
    logic [word_width-1:0]     reg_rdata;
    logic [insn_width-1:0]     insn;
    decoded_insn_t             decoded;

    integer      seed;
    int unsigned edge_count = 0;
    int          cycle_count = 0;

    logic [word_width-1:0]     inst_model [logic [ram_addr_width-1:0]];
    logic [word_width-1:0]     data_model [logic [ram_addr_width-1:0]];
    logic [ram_addr_width-1:0] addr_list [ram_checks];

    word_exp_t inst_exp_q [$];
    word_exp_t data_exp_q [$];
    word_exp_t reg_exp_q [$];
    dec_exp_t  dec_exp_q [$];

    tb_clock_gen clock_gen (
        .clock (clock),
        .rst_n (rst_n)
    );

    rv_core_top dut0 (
        .clock         (clock),
        .rst_n         (rst_n),
        .led           (led),
        .inst_req      (inst_req),
        .inst_rdata    (inst_rdata),
        .data_req      (data_req),
        .data_rdata    (data_rdata),
        .reg_read_addr (reg_read_addr),
        .reg_read_en   (reg_read_en),
        .reg_rdata     (reg_rdata),
        .insn          (insn),
        .decoded       (decoded)
    );

    // Rising edges since reset release.
    always @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            edge_count <= 0;
        end else begin
            edge_count <= edge_count + 1;
        end
    end

    // x1 gains one on every fourth edge; a read sees the value before its edge.
    function automatic logic [word_width-1:0] ref_x1(input int unsigned edges);
        return edges / 4;
    endfunction

    // Low after reset, then flips once every four edges.
    function automatic logic ref_led(input int unsigned edges);
        return ((edges / 4) % 2) == 1;
    endfunction

    function automatic decoded_insn_t ref_decode(input logic [insn_width-1:0] word);
        decoded_insn_t d;
        case (word[6:0])
            opc_lui:     d.op_class = op_lui;
            opc_auipc:   d.op_class = op_auipc;
            opc_jal:     d.op_class = op_jal;
            opc_jalr:    d.op_class = op_jalr;
            opc_branch:  d.op_class = op_branch;
            opc_load:    d.op_class = op_load;
            opc_store:   d.op_class = op_store;
            opc_alu_imm: d.op_class = op_alu_imm;
            opc_alu_reg: d.op_class = op_alu_reg;
            opc_system:  d.op_class = op_system;
            default:     d.op_class = op_illegal;
        endcase
        d.rd     = word[11:7];
        d.funct3 = word[14:12];
        d.rs1    = word[19:15];
        d.rs2    = word[24:20];
        d.funct7 = word[31:25];
        d.imm    = {{20{word[31]}}, word[31:20]};
        return d;
    endfunction

    function automatic logic [31:0] next_edge();
        return edge_count + 32'd1;
    endfunction

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [ram_addr_width-1:0] rand_addr();
        logic [31:0] r;
        r = $random(seed);
        return r[ram_addr_width-1:0];
    endfunction

    task automatic abort_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [word_width-1:0] expected,
                              input logic [word_width-1:0] actual);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected %b, got %b", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_decoded(input string name, input decoded_insn_t expected,
                                 input decoded_insn_t actual);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected %h (class %0d), got %h (class %0d)",
                     $time, name, expected, expected.op_class, actual, actual.op_class);
            abort_run();
        end
    endtask

    task automatic ram_write(input bit to_data, input logic [ram_addr_width-1:0] addr,
                             input logic [word_width-1:0] data);
        if (to_data) begin
            data_req.addr       = addr;
            data_req.write_en   = 1'b1;
            data_req.write_data = data;
            data_model[addr]    = data;
        end else begin
            inst_req.addr       = addr;
            inst_req.write_en   = 1'b1;
            inst_req.write_data = data;
            inst_model[addr]    = data;
        end
    endtask

    task automatic ram_read(input bit to_data, input logic [ram_addr_width-1:0] addr);
        if (to_data) begin
            data_req.addr       = addr;
            data_req.write_en   = 1'b0;
            data_req.write_data = '0;
            data_exp_q.push_back('{due: next_edge(), value: data_model[addr]});
        end else begin
            inst_req.addr       = addr;
            inst_req.write_en   = 1'b0;
            inst_req.write_data = '0;
            inst_exp_q.push_back('{due: next_edge(), value: inst_model[addr]});
        end
    endtask

    task automatic apply_insn(input logic [insn_width-1:0] word);
        insn = word;
        dec_exp_q.push_back('{due: next_edge(), value: ref_decode(word)});
    endtask

    // Reads x0 or x1 in roughly one cycle of four.
    task automatic random_reg_read();
        logic [31:0] r;
        r = rand_word();
        reg_read_en   = r[0] & r[1];
        reg_read_addr = r[2] ? inc_target_reg : reg_addr_width'(0);
        if (reg_read_en) begin
            if (reg_read_addr == '0) begin
                reg_exp_q.push_back('{due: next_edge(), value: '0});
            end else begin
                reg_exp_q.push_back('{due: next_edge(), value: ref_x1(next_edge())});
            end
        end
    endtask

    task automatic end_cycle();
        random_reg_read();
        @(negedge clock);
        inst_req.write_en = 1'b0;
        data_req.write_en = 1'b0;
    endtask

    task automatic check_reset_state();
        decoded_insn_t cleared;
        cleared          = '0;
        cleared.op_class = op_illegal;
        check_bit("led", 1'b0, led);
        check_decoded("decoded", cleared, decoded);
        check_word("reg_rdata", '0, reg_rdata);
    endtask

    // Results are compared on the falling edge after they become visible.
    always @(negedge clock) begin : compare_results
        word_exp_t w;
        dec_exp_t  d;
        if (rst_n) begin
            check_bit("led", ref_led(edge_count), led);
            if (inst_exp_q.size() > 0 && inst_exp_q[0].due == edge_count) begin
                w = inst_exp_q.pop_front();
                check_word("inst_rdata", w.value, inst_rdata);
            end
            if (data_exp_q.size() > 0 && data_exp_q[0].due == edge_count) begin
                w = data_exp_q.pop_front();
                check_word("data_rdata", w.value, data_rdata);
            end
            if (reg_exp_q.size() > 0 && reg_exp_q[0].due == edge_count) begin
                w = reg_exp_q.pop_front();
                check_word("reg_rdata", w.value, reg_rdata);
            end
            if (dec_exp_q.size() > 0 && dec_exp_q[0].due == edge_count) begin
                d = dec_exp_q.pop_front();
                check_decoded("decoded", d.value, decoded);
            end
        end
    end

    always @(negedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("Timeout: the run did not end within %0d cycles.", max_cycles);
            abort_run();
        end
    end

    initial begin
        int          i;
        logic [31:0] r;
        seed          = 77669;
        inst_req      = '0;
        data_req      = '0;
        reg_read_addr = '0;
        reg_read_en   = 1'b0;
        insn          = '0;

        @(negedge clock);
        check_reset_state();
        // First x1 read is sampled on the first edge after release.
        reg_read_addr = inc_target_reg;
        reg_read_en   = 1'b1;
        reg_exp_q.push_back('{due: 32'd1, value: ref_x1(1)});
        wait (rst_n === 1'b1);
        @(negedge clock);

        // Instruction RAM alone.
        for (i = 0; i < ram_checks; i++) begin
            addr_list[i] = rand_addr();
            ram_write(1'b0, addr_list[i], rand_word());
            end_cycle();
        end
        for (i = 0; i < ram_checks; i++) begin
            ram_read(1'b0, addr_list[i]);
            end_cycle();
        end

        // Both RAMs, same addresses, different data.
        for (i = 0; i < ram_checks; i++) begin
            addr_list[i] = rand_addr();
            ram_write(1'b0, addr_list[i], rand_word());
            ram_write(1'b1, addr_list[i], rand_word());
            end_cycle();
        end
        for (i = 0; i < ram_checks; i++) begin
            ram_read(1'b0, addr_list[i]);
            ram_read(1'b1, addr_list[i]);
            end_cycle();
        end

        // Decoder, one word per class, then random words.
        for (i = 0; i < 11; i++) begin
            r = rand_word();
            apply_insn({r[31:7], class_opcodes[i]});
            end_cycle();
        end
        for (i = 0; i < random_insns; i++) begin
            apply_insn(rand_word());
            end_cycle();
        end

        // Let x1 keep counting under random reads.
        for (i = 0; i < soak_cycles; i++) begin
            end_cycle();
        end

        reg_read_en = 1'b0;
        while (inst_exp_q.size() + data_exp_q.size() + reg_exp_q.size()
               + dec_exp_q.size() != 0) begin
            @(negedge clock);
        end
        @(negedge clock);
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic rst_n
);

    // 4 ns period.
    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Reset spans two rising edges and lifts on a falling edge.
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* design/block_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module block_ram (
    input  wire                            clock,
    input  wire mem_pkg::mem_req_t         req,
    output logic [mem_pkg::word_width-1:0] rdata
);

    import mem_pkg::*;

    logic [word_width-1:0] mem [ram_depth];

    // Single port. A write blocks the read for that cycle,
    // so rdata keeps its previous value.
    always_ff @(posedge clock) begin
        if (req.write_en) begin
            mem[req.addr] <= req.write_data;
        end else begin
            rdata <= mem[req.addr];
        end
    end

endmodule

`default_nettype wire

/* design/insn_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module insn_decoder (
    input  wire                             clock,
    input  wire                             rst_n,
    input  wire [rv_pkg::insn_width-1:0]    insn,
    output rv_pkg::decoded_insn_t           decoded
);

    import rv_pkg::*;

    decoded_insn_t next_decoded;

    always_comb begin
        // Major class from the low seven bits.
        case (insn[opcode_width-1:0])
            opc_lui:     next_decoded.op_class = op_lui;
            opc_auipc:   next_decoded.op_class = op_auipc;
            opc_jal:     next_decoded.op_class = op_jal;
            opc_jalr:    next_decoded.op_class = op_jalr;
            opc_branch:  next_decoded.op_class = op_branch;
            opc_load:    next_decoded.op_class = op_load;
            opc_store:   next_decoded.op_class = op_store;
            opc_alu_imm: next_decoded.op_class = op_alu_imm;
            opc_alu_reg: next_decoded.op_class = op_alu_reg;
            opc_system:  next_decoded.op_class = op_system;
            default:     next_decoded.op_class = op_illegal;
        endcase

        // Fields sit at fixed positions for every format.
        next_decoded.rd     = insn[11:7];
        next_decoded.funct3 = insn[14:12];
        next_decoded.rs1    = insn[19:15];
        next_decoded.rs2    = insn[24:20];
        next_decoded.funct7 = insn[31:25];

        // I-type immediate, sign extended.
        next_decoded.imm = {{(insn_width - i_imm_width){insn[31]}}, insn[31:20]};
    end

    // Result is valid one cycle after insn.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            decoded.op_class <= op_illegal;
            decoded.rd       <= '0;
            decoded.rs1      <= '0;
            decoded.rs2      <= '0;
            decoded.funct3   <= '0;
            decoded.funct7   <= '0;
            decoded.imm      <= '0;
        end else begin
            decoded <= next_decoded;
        end
    end

endmodule

`default_nettype wire

/* design/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // Data word shared by both RAMs and the register bank.
    localparam int word_width = 32;

    // Both RAMs use the same address width.
    localparam int ram_addr_width = 16;
    localparam int ram_depth = 2 ** ram_addr_width;

    // Register bank index and size.
    localparam int reg_addr_width = 5;
    localparam int reg_count = 2 ** reg_addr_width;

    // Register that the increment sequencer works on (x1).
    localparam logic [reg_addr_width-1:0] inc_target_reg = reg_addr_width'(1);

    // One RAM request.
    // Reads happen whenever write_en is low.
    typedef struct packed {
        logic [ram_addr_width-1:0] addr;
        logic                      write_en;
        logic [word_width-1:0]     write_data;
    } mem_req_t;

    // Phases of the x1 increment sequencer.
    typedef enum logic [1:0] {
        seq_read,
        seq_wait_read,
        seq_write,
        seq_wait_write
    } seq_state_t;

endpackage

`default_nettype wire

/* design/reg_incrementer.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_incrementer (
    input  wire                                clock,
    input  wire                                rst_n,

    output logic [mem_pkg::reg_addr_width-1:0] read_addr,
    output logic                               read_en,
    input  wire [mem_pkg::word_width-1:0]      read_data,

    output logic [mem_pkg::reg_addr_width-1:0] write_addr,
    output logic                               write_en,
    output logic [mem_pkg::word_width-1:0]     write_data
);

    import mem_pkg::*;

    seq_state_t state;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state      <= seq_read;
            read_addr  <= '0;
            read_en    <= 1'b0;
            write_addr <= '0;
            write_en   <= 1'b0;
        end else begin
            case (state)
                seq_read: begin
                    // Request x1. The bank samples it at the next edge.
                    read_addr <= inc_target_reg;
                    read_en   <= 1'b1;
                    state     <= seq_wait_read;
                end
                seq_wait_read: begin
                    read_en    <= 1'b0;
                    write_addr <= inc_target_reg;
                    write_en   <= 1'b1;
                    state      <= seq_write;
                end
                seq_write: begin
                    // Write lands on this edge.
                    write_en <= 1'b0;
                    state    <= seq_wait_write;
                end
                seq_wait_write: begin
                    state <= seq_read;
                end
                default: begin
                    state <= seq_read;
                end
            endcase
        end
    end

    // Read data is valid during seq_write and held by the bank afterwards.
    assign write_data = read_data + word_width'(1);

endmodule

`default_nettype wire

/* design/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire                                clock,
    input  wire                                rst_n,

    input  wire [mem_pkg::reg_addr_width-1:0]  write_addr,
    input  wire                                write_en,
    input  wire [mem_pkg::word_width-1:0]      write_data,

    input  wire [mem_pkg::reg_addr_width-1:0]  read1_addr,
    input  wire                                read1_en,
    output logic [mem_pkg::word_width-1:0]     read1_data,

    input  wire [mem_pkg::reg_addr_width-1:0]  read2_addr,
    input  wire                                read2_en,
    output logic [mem_pkg::word_width-1:0]     read2_data
);

    import mem_pkg::*;

    logic [word_width-1:0] regs [reg_count];

    // Write port. x0 is hardwired to zero.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && (write_addr != '0)) begin
            regs[write_addr] <= write_data;
        end
    end

    // Two independent read ports.
    // Same-cycle write is not forwarded; reads see the old value.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            read1_data <= '0;
            read2_data <= '0;
        end else begin
            if (read1_en) begin
                read1_data <= regs[read1_addr];
            end
            if (read2_en) begin
                read2_data <= regs[read2_addr];
            end
        end
    end

endmodule

`default_nettype wire

/* design/rv_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
    input  wire                                 clock,
    input  wire                                 rst_n,
    output wire                                 led,

    // Instruction RAM access.
    input  wire mem_pkg::mem_req_t              inst_req,
    output wire [mem_pkg::word_width-1:0]       inst_rdata,

    // Data RAM access.
    input  wire mem_pkg::mem_req_t              data_req,
    output wire [mem_pkg::word_width-1:0]       data_rdata,

    // External register read.
    input  wire [mem_pkg::reg_addr_width-1:0]   reg_read_addr,
    input  wire                                 reg_read_en,
    output wire [mem_pkg::word_width-1:0]       reg_rdata,

    // Decoder.
    input  wire [rv_pkg::insn_width-1:0]        insn,
    output rv_pkg::decoded_insn_t               decoded
);

    import mem_pkg::*;

    // Sequencer to register bank.
    logic [reg_addr_width-1:0] inc_read_addr;
    logic                      inc_read_en;
    logic [word_width-1:0]     inc_read_data;
    logic [reg_addr_width-1:0] inc_write_addr;
    logic                      inc_write_en;
    logic [word_width-1:0]     inc_write_data;

    // LED divider. Bit 2 toggles every four cycles.
    logic [2:0] led_count;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            led_count <= '0;
        end else begin
            led_count <= led_count + 3'd1;
        end
    end

    assign led = led_count[2];

    block_ram inst_ram (
        .clock (clock),
        .req   (inst_req),
        .rdata (inst_rdata)
    );

    block_ram data_ram (
        .clock (clock),
        .req   (data_req),
        .rdata (data_rdata)
    );

    // Port 1 is external, port 2 belongs to the sequencer.
    register_file registers (
        .clock      (clock),
        .rst_n      (rst_n),
        .write_addr (inc_write_addr),
        .write_en   (inc_write_en),
        .write_data (inc_write_data),
        .read1_addr (reg_read_addr),
        .read1_en   (reg_read_en),
        .read1_data (reg_rdata),
        .read2_addr (inc_read_addr),
        .read2_en   (inc_read_en),
        .read2_data (inc_read_data)
    );

    insn_decoder decoder (
        .clock   (clock),
        .rst_n   (rst_n),
        .insn    (insn),
        .decoded (decoded)
    );

    reg_incrementer incrementer (
        .clock      (clock),
        .rst_n      (rst_n),
        .read_addr  (inc_read_addr),
        .read_en    (inc_read_en),
        .read_data  (inc_read_data),
        .write_addr (inc_write_addr),
        .write_en   (inc_write_en),
        .write_data (inc_write_data)
    );

endmodule

`default_nettype wire

/* design/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // Instruction word and field widths.
    localparam int insn_width = 32;
    localparam int opcode_width = 7;
    localparam int reg_field_width = 5;
    localparam int funct3_width = 3;
    localparam int funct7_width = 7;
    localparam int i_imm_width = 12;

    // Major opcode table, low seven bits of the instruction.
    localparam logic [opcode_width-1:0] opc_lui     = 7'b0110111;
    localparam logic [opcode_width-1:0] opc_auipc   = 7'b0010111;
    localparam logic [opcode_width-1:0] opc_jal     = 7'b1101111;
    localparam logic [opcode_width-1:0] opc_jalr    = 7'b1100111;
    localparam logic [opcode_width-1:0] opc_branch  = 7'b1100011;
    localparam logic [opcode_width-1:0] opc_load    = 7'b0000011;
    localparam logic [opcode_width-1:0] opc_store   = 7'b0100011;
    localparam logic [opcode_width-1:0] opc_alu_imm = 7'b0010011;
    localparam logic [opcode_width-1:0] opc_alu_reg = 7'b0110011;
    localparam logic [opcode_width-1:0] opc_system  = 7'b1110011;

    // Opcode classes seen by the rest of the design.
    typedef enum logic [3:0] {
        op_lui,
        op_auipc,
        op_jal,
        op_jalr,
        op_branch,
        op_load,
        op_store,
        op_alu_imm,
        op_alu_reg,
        op_system,
        op_illegal
    } opcode_t;

    // One decoded instruction.
    typedef struct packed {
        opcode_t                    op_class;
        logic [reg_field_width-1:0] rd;
        logic [reg_field_width-1:0] rs1;
        logic [reg_field_width-1:0] rs2;
        logic [funct3_width-1:0]    funct3;
        logic [funct7_width-1:0]    funct7;
        logic [insn_width-1:0]      imm;
    } decoded_insn_t;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the rv_core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_exe=rv_core_sim
log_file=sim.log

verilator --binary --timing --assert -j 0 \
    -f sim.f \
    --top-module rv_core_tb \
    -Mdir "$build_dir" \
    -o "$sim_exe"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/$sim_exe" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if grep -q "Something failed" "$log_file"; then
    echo "Simulation FAILED"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

echo "Simulation PASSED"
exit 0

/* sim.f */
design/mem_pkg.sv
design/rv_pkg.sv
design/block_ram.sv
design/register_file.sv
design/insn_decoder.sv
design/reg_incrementer.sv
design/rv_core_top.sv
bench/tb_clock_gen.sv
bench/rv_core_sva.sv
bench/rv_core_tb.sv
